// ==== testbench/rom_check_testdata.hex ====
// Per image: expected-good flag word, then ROM words at addresses 0 to 7
// Addresses 6 and 7 hold digest lane 0 and lane 1
00000001
00000001
00000010
00000100
00001000
80000000
12345678
12341F59
92346789
// Second image carries a wrong lane 1 digest word
00000000
00000001
00000002
00000003
00000004
00000005
00000006
00000004
00000016

// ==== project.f ====
src/rom_check_pkg.sv
src/rom_check_ctrl_pkg.sv
src/rom_addr_counter.sv
src/rom_hash_engine.sv
src/rom_digest_compare.sv
src/rom_check_fsm.sv
src/rom_access_mux.sv
src/rom_check_top.sv
testbench/rom_check_chk.sv
testbench/rom_check_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= rom_check_tb
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_TEXT ?= TEST RESULT: PASS

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --assert -f $(FILELIST) --top-module $(TOP)

$(BUILD_DIR)/V$(TOP): $(shell cat $(FILELIST))
	$(VERILATOR) --binary --timing --assert -f $(FILELIST) --top-module $(TOP) \
		-Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== testbench/rom_check_tb.sv ====
// Testbench for the ROM integrity checker
// ROM model, reference hash, random bus traffic, address order monitor and per-image checks

`timescale 1ns/1ns

module rom_check_tb;

  localparam int unsigned ImageWords = rom_check_pkg::RomDepth + 1;
  localparam int unsigned ImageCount = 2;
  localparam int unsigned DoneTimeout = 2000;
  localparam int unsigned BusReads = 8;

  logic                     clk_i = 1'b0;
  logic                     rst_ni = 1'b0;
  rom_check_pkg::rom_addr_t rom_addr_o;
  logic                     rom_req_o;
  rom_check_pkg::rom_word_t rom_data_i = '0;
  rom_check_pkg::rom_addr_t bus_addr_i = '0;
  logic                     bus_req_i = 1'b0;
  rom_check_pkg::rom_word_t bus_rdata_o;
  rom_check_pkg::digest_t   digest_o;
  logic                     check_done_o;
  logic                     check_good_o;
  logic                     alert_o;

  // Each image is a flag word followed by the ROM contents
  rom_check_pkg::rom_word_t file_words [ImageCount*ImageWords];
  rom_check_pkg::rom_word_t rom_q [rom_check_pkg::RomDepth];

  // Bus traffic is random while the checker owns the ROM, scripted afterwards
  logic                     bus_random = 1'b1;
  logic                     cmd_req = 1'b0;
  rom_check_pkg::rom_addr_t cmd_addr = '0;

  logic                     have_prev = 1'b0;
  rom_check_pkg::rom_addr_t prev_addr = '0;
  logic                     alert_seen = 1'b0;

  int unsigned checks = 0;
  int unsigned errors = 0;
  int unsigned tests_run = 0;
  int unsigned tests_failed = 0;

  rom_check_top dut_i (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .rom_addr_o   (rom_addr_o),
    .rom_req_o    (rom_req_o),
    .rom_data_i   (rom_data_i),
    .bus_addr_i   (bus_addr_i),
    .bus_req_i    (bus_req_i),
    .bus_rdata_o  (bus_rdata_o),
    .digest_o     (digest_o),
    .check_done_o (check_done_o),
    .check_good_o (check_good_o),
    .alert_o      (alert_o)
  );

  always #50 clk_i = ~clk_i;

  // ROM answers a request on the next rising edge
  always @(posedge clk_i) begin
    if (rom_req_o) begin
      rom_data_i <= rom_q[rom_addr_o];
    end
  end

  always @(posedge clk_i) begin
    if (bus_random) begin
      bus_req_i  <= 1'($urandom_range(0, 1));
      bus_addr_i <= rom_check_pkg::rom_addr_t'($urandom);
    end else begin
      bus_req_i  <= cmd_req;
      bus_addr_i <= cmd_addr;
    end
  end

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    checks++;
    if (expected !== actual) begin
      errors++;
      $display("[FAIL] %s expected %0h actual %0h", name, expected, actual);
    end
  endtask

  // Before done the ROM port must walk the addresses in order, a stall repeats the address
  always @(posedge clk_i) begin
    if (!rst_ni) begin
      have_prev  <= 1'b0;
      alert_seen <= 1'b0;
    end else begin
      if (alert_o) begin
        alert_seen <= 1'b1;
      end
      if (!check_done_o && rom_req_o) begin
        if (!have_prev) begin
          check_value("addr_order", 64'(0), 64'(rom_addr_o));
        end else if (rom_addr_o != prev_addr) begin
          check_value("addr_order", 64'(prev_addr + 1'b1), 64'(rom_addr_o));
        end
        have_prev <= 1'b1;
        prev_addr <= rom_addr_o;
      end
    end
  end

  // Two lanes over the non-top words, lane 0 rotates and XORs, lane 1 sums
  function automatic rom_check_pkg::digest_t reference_hash();
    rom_check_pkg::rom_word_t lane0;
    rom_check_pkg::rom_word_t lane1;
    lane0 = '0;
    lane1 = '0;
    for (int i = 0; i < rom_check_pkg::TopStart; i++) begin
      lane0 = {lane0[30:0], lane0[31]} ^ rom_q[i];
      lane1 = lane1 + rom_q[i];
    end
    return {lane1, lane0};
  endfunction

  task automatic wait_done(output logic timed_out);
    int unsigned cycles;
    cycles = 0;
    timed_out = 1'b0;
    while (!check_done_o && !timed_out) begin
      @(negedge clk_i);
      cycles++;
      if (cycles >= DoneTimeout) begin
        timed_out = 1'b1;
      end
    end
  endtask

  // One bus read takes a request cycle and a data cycle
  task automatic bus_read(input rom_check_pkg::rom_addr_t addr);
    cmd_req  = 1'b1;
    cmd_addr = addr;
    @(negedge clk_i);
    cmd_req = 1'b0;
    @(negedge clk_i);
    check_value("bus_read", 64'(rom_q[addr]), 64'(bus_rdata_o));
  endtask

  task automatic finish_test(input string name, input int unsigned errors_before);
    tests_run++;
    if (errors == errors_before) begin
      $display("test %s: ok", name);
    end else begin
      tests_failed++;
      $display("test %s: failed with %0d errors", name, errors - errors_before);
    end
  endtask

  task automatic run_image(input int unsigned k);
    logic                   timed_out;
    logic                   flag;
    logic                   ref_good;
    rom_check_pkg::digest_t ref_digest;
    int unsigned            mark;
    string                  tag;
    tag = $sformatf("image%0d", k);
    @(negedge clk_i);
    flag = file_words[k*ImageWords][0];
    for (int i = 0; i < rom_check_pkg::RomDepth; i++) begin
      rom_q[i] = file_words[k*ImageWords + 1 + i];
    end
    bus_random = 1'b1;
    @(posedge clk_i);
    rst_ni <= 1'b0;
    repeat (5) @(posedge clk_i);
    rst_ni <= 1'b1;
    mark = errors;
    wait_done(timed_out);
    if (timed_out) begin
      errors++;
      $display("%s: check_done_o did not rise within %0d cycles", tag, DoneTimeout);
    end
    finish_test({tag, "_done"}, mark);
    if (!timed_out) begin
      ref_digest = reference_hash();
      // Word 0 of the digest belongs at the first top address
      ref_good = (ref_digest == {rom_q[rom_check_pkg::TopStart + 1],
                                 rom_q[rom_check_pkg::TopStart]});
      mark = errors;
      check_value({tag, "_good_flag"}, 64'(flag), 64'(check_good_o));
      check_value({tag, "_good_rule"}, 64'(ref_good), 64'(check_good_o));
      finish_test({tag, "_good"}, mark);
      mark = errors;
      check_value({tag, "_digest"}, ref_digest, digest_o);
      finish_test({tag, "_digest"}, mark);
      mark = errors;
      bus_random = 1'b0;
      for (int i = 0; i < BusReads; i++) begin
        bus_read(rom_check_pkg::rom_addr_t'($urandom));
      end
      finish_test({tag, "_bus"}, mark);
    end
    mark = errors;
    check_value({tag, "_alert"}, 64'(0), 64'(alert_seen));
    finish_test({tag, "_alert"}, mark);
  endtask

  initial begin
    void'($urandom(95));
    $readmemh("testbench/rom_check_testdata.hex", file_words);
    for (int k = 0; k < ImageCount; k++) begin
      run_image(k);
    end
    $display("tests %0d, failed %0d, checks %0d, mismatches %0d",
             tests_run, tests_failed, checks, errors);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

// ==== testbench/rom_check_chk.sv ====
// Assertions on the FSM word handshake and the alert output, bound into the FSM

`timescale 1ns/1ns

module rom_check_chk (
  input logic clk_i,
  input logic rst_ni,
  input logic word_valid_i,
  input logic word_ready_i,
  input logic word_last_i,
  input logic alert_i
);

  // The last marker only means something on an offered word
  last_needs_valid: assert property (@(posedge clk_i) disable iff (!rst_ni)
    word_last_i |-> word_valid_i)
    else $error("word_last without word_valid");

  // An offered word is held until the hash engine takes it
  valid_holds: assert property (@(posedge clk_i) disable iff (!rst_ni)
    word_valid_i && !word_ready_i |=> word_valid_i)
    else $error("word_valid dropped before transfer");

  no_alert: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !alert_i)
    else $error("alert raised");

endmodule

bind rom_check_fsm rom_check_chk u_chk (
  .clk_i        (clk_i),
  .rst_ni       (rst_ni),
  .word_valid_i (word_valid_o),
  .word_ready_i (word_ready_i),
  .word_last_i  (word_last_o),
  .alert_i      (alert_o)
);

// ==== src/rom_check_top.sv ====
// Top level of the boot-time ROM integrity checker
// Wires the address counter, hash engine, digest compare, FSM and ROM port mux

`timescale 1ns/1ns

module rom_check_top (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  output rom_check_pkg::rom_addr_t  rom_addr_o,
  output logic                      rom_req_o,
  input  rom_check_pkg::rom_word_t  rom_data_i,
  input  rom_check_pkg::rom_addr_t  bus_addr_i,
  input  logic                      bus_req_i,
  output rom_check_pkg::rom_word_t  bus_rdata_o,
  output rom_check_pkg::digest_t    digest_o,
  output logic                      check_done_o,
  output logic                      check_good_o,
  output logic                      alert_o
);

  // Counter side
  rom_check_pkg::rom_addr_t cnt_read_addr, cnt_data_addr;
  logic                     cnt_read_req, cnt_last_nontop, cnt_done, cnt_data_rdy;
  // Hash handshake
  logic                     word_valid, word_last, word_ready, hash_done;
  // Compare side
  logic                     exp_valid, cmp_start, cmp_done;
  rom_check_pkg::top_idx_t  exp_idx;

  rom_addr_counter u_counter (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .data_rdy_i    (cnt_data_rdy),
    .read_addr_o   (cnt_read_addr),
    .read_req_o    (cnt_read_req),
    .data_addr_o   (cnt_data_addr),
    .last_nontop_o (cnt_last_nontop),
    .done_o        (cnt_done)
  );

  // The hash reads words straight off the ROM data bus
  rom_hash_engine u_hash (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .word_i       (rom_data_i),
    .word_valid_i (word_valid),
    .word_last_i  (word_last),
    .word_ready_o (word_ready),
    .done_o       (hash_done),
    .digest_o     (digest_o)
  );

  rom_digest_compare u_compare (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .exp_valid_i   (exp_valid),
    .exp_idx_i     (exp_idx),
    .exp_word_i    (rom_data_i),
    .hash_done_i   (hash_done),
    .hash_digest_i (digest_o),
    .start_i       (cmp_start),
    .done_o        (cmp_done),
    .good_o        (check_good_o)
  );

  rom_check_fsm u_fsm (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .rom_data_i        (rom_data_i),
    .cnt_data_addr_i   (cnt_data_addr),
    .cnt_read_req_i    (cnt_read_req),
    .cnt_last_nontop_i (cnt_last_nontop),
    .cnt_done_i        (cnt_done),
    .cnt_data_rdy_o    (cnt_data_rdy),
    .word_valid_o      (word_valid),
    .word_last_o       (word_last),
    .word_ready_i      (word_ready),
    .hash_done_i       (hash_done),
    .cmp_done_i        (cmp_done),
    .exp_valid_o       (exp_valid),
    .exp_idx_o         (exp_idx),
    .cmp_start_o       (cmp_start),
    .check_done_o      (check_done_o),
    .alert_o           (alert_o)
  );

  // The port goes to the bus once the check is done
  rom_access_mux u_mux (
    .select_bus_i (check_done_o),
    .cnt_addr_i   (cnt_read_addr),
    .cnt_req_i    (cnt_read_req),
    .bus_addr_i   (bus_addr_i),
    .bus_req_i    (bus_req_i),
    .rom_addr_o   (rom_addr_o),
    .rom_req_o    (rom_req_o)
  );

  // Read data is shared, only the request path is muxed
  assign bus_rdata_o = rom_data_i;

endmodule

// ==== src/rom_access_mux.sv ====
// ROM port selection between the integrity checker and the system bus

`timescale 1ns/1ns

module rom_access_mux (
  input  logic                      select_bus_i,
  input  rom_check_pkg::rom_addr_t  cnt_addr_i,
  input  logic                      cnt_req_i,
  input  rom_check_pkg::rom_addr_t  bus_addr_i,
  input  logic                      bus_req_i,
  output rom_check_pkg::rom_addr_t  rom_addr_o,
  output logic                      rom_req_o
);

  // The checker owns the port from reset, bus requests are dropped until then
  always_comb begin
    if (select_bus_i) begin
      rom_addr_o = bus_addr_i;
      rom_req_o  = bus_req_i;
    end else begin
      rom_addr_o = cnt_addr_i;
      rom_req_o  = cnt_req_i;
    end
  end

endmodule

// ==== src/rom_check_fsm.sv ====
// Sequencing FSM for the ROM integrity check
// Drives the hash word handshake, top-word capture and the compare start
// Runs consistency checks on the done signals and raises the alert

`timescale 1ns/1ns

module rom_check_fsm (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  rom_check_pkg::rom_word_t  rom_data_i,
  input  rom_check_pkg::rom_addr_t  cnt_data_addr_i,
  input  logic                      cnt_read_req_i,
  input  logic                      cnt_last_nontop_i,
  input  logic                      cnt_done_i,
  output logic                      cnt_data_rdy_o,
  output logic                      word_valid_o,
  output logic                      word_last_o,
  input  logic                      word_ready_i,
  input  logic                      hash_done_i,
  input  logic                      cmp_done_i,
  output logic                      exp_valid_o,
  output rom_check_pkg::top_idx_t   exp_idx_o,
  output logic                      cmp_start_o,
  output logic                      check_done_o,
  output logic                      alert_o
);

  rom_check_ctrl_pkg::fsm_state_e state_d, state_q;
  logic                           word_valid_d, word_valid_q;
  logic                           transfer;
  logic                           reading_top;
  logic                           held_q;
  rom_check_pkg::rom_word_t       held_word_q;
  logic                           data_changed;
  logic                           counter_dropped;
  logic                           cmp_start_q;

  assign transfer    = word_valid_q & word_ready_i;
  assign reading_top = state_q inside {rom_check_ctrl_pkg::ReadingHigh,
                                       rom_check_ctrl_pkg::HashAhead};

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      // Move on once the last non-top word has gone to the hash
      rom_check_ctrl_pkg::ReadingLow: begin
        if (cnt_last_nontop_i && transfer) begin
          state_d = rom_check_ctrl_pkg::ReadingHigh;
        end
      end
      // Top reads race the hash, whichever finishes first picks the branch
      rom_check_ctrl_pkg::ReadingHigh: begin
        unique case ({hash_done_i, cnt_done_i})
          2'b01:   state_d = rom_check_ctrl_pkg::RomAhead;
          2'b10:   state_d = rom_check_ctrl_pkg::HashAhead;
          2'b11:   state_d = rom_check_ctrl_pkg::Checking;
          default: state_d = state_q;
        endcase
      end
      rom_check_ctrl_pkg::RomAhead: begin
        if (hash_done_i) state_d = rom_check_ctrl_pkg::Checking;
      end
      rom_check_ctrl_pkg::HashAhead: begin
        if (cnt_done_i) state_d = rom_check_ctrl_pkg::Checking;
      end
      rom_check_ctrl_pkg::Checking: begin
        if (cmp_done_i) state_d = rom_check_ctrl_pkg::Done;
      end
      rom_check_ctrl_pkg::Done: begin
        state_d = rom_check_ctrl_pkg::Done;
      end
      default: begin
        state_d = rom_check_ctrl_pkg::Invalid;
      end
    endcase

    // A done signal showing up in a state that cannot expect it means the order was broken
    if ((cmp_done_i && !(state_q inside {rom_check_ctrl_pkg::Checking,
                                         rom_check_ctrl_pkg::Done})) ||
        (cnt_done_i && state_q == rom_check_ctrl_pkg::ReadingLow) ||
        (hash_done_i && !(state_q inside {rom_check_ctrl_pkg::ReadingHigh,
                                          rom_check_ctrl_pkg::RomAhead}))) begin
      state_d = rom_check_ctrl_pkg::Invalid;
    end
    // Any alert also locks the FSM up
    if (alert_o) begin
      state_d = rom_check_ctrl_pkg::Invalid;
    end
  end

  // Valid goes up for each word read in ReadingLow and drops when the hash takes it
  always_comb begin
    word_valid_d = word_valid_q;
    if (word_ready_i) begin
      word_valid_d = 1'b0;
    end
    if (cnt_read_req_i && state_q == rom_check_ctrl_pkg::ReadingLow && !cnt_last_nontop_i) begin
      word_valid_d = 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q      <= rom_check_ctrl_pkg::ReadingLow;
      word_valid_q <= 1'b0;
      held_q       <= 1'b0;
      cmp_start_q  <= 1'b0;
    end else begin
      state_q      <= state_d;
      word_valid_q <= word_valid_d;
      held_q       <= word_valid_q & ~word_ready_i;
      // Strobe in the first cycle spent in Checking
      cmp_start_q  <= (state_q != rom_check_ctrl_pkg::Checking) &&
                      (state_d == rom_check_ctrl_pkg::Checking);
    end
  end

  // Snapshot of the offered word, so a stalled word can be checked for stability
  always_ff @(posedge clk_i) begin
    held_word_q <= rom_data_i;
  end

  assign data_changed    = held_q & word_valid_q & (rom_data_i != held_word_q);
  // The counter must stay done once the bus owns the ROM
  assign counter_dropped = (state_q == rom_check_ctrl_pkg::Done) & ~cnt_done_i;

  // Non-top words advance on a transfer, top words every cycle
  assign cnt_data_rdy_o = transfer | reading_top;
  assign word_valid_o   = word_valid_q;
  assign word_last_o    = cnt_last_nontop_i;

  assign exp_valid_o  = reading_top & ~cnt_done_i;
  assign exp_idx_o    = rom_check_pkg::top_idx_t'(cnt_data_addr_i - rom_check_pkg::TopStartAddr);
  assign cmp_start_o  = cmp_start_q;
  assign check_done_o = (state_q == rom_check_ctrl_pkg::Done);
  assign alert_o      = (state_q == rom_check_ctrl_pkg::Invalid) | data_changed | counter_dropped;

endmodule

// ==== src/rom_digest_compare.sv ====
// Expected digest store and word-serial digest comparator
// Produces a done strobe and a sticky good level

`timescale 1ns/1ns

module rom_digest_compare (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      exp_valid_i,
  input  rom_check_pkg::top_idx_t   exp_idx_i,
  input  rom_check_pkg::rom_word_t  exp_word_i,
  input  logic                      hash_done_i,
  input  rom_check_pkg::digest_t    hash_digest_i,
  input  logic                      start_i,
  output logic                      done_o,
  output logic                      good_o
);

  rom_check_pkg::rom_word_t exp_q [rom_check_pkg::TopCount];
  rom_check_pkg::digest_t   digest_q;
  rom_check_pkg::top_idx_t  idx_q;
  rom_check_pkg::rom_word_t hash_word;
  logic                     busy_q, match_q, done_q, good_q;
  logic                     word_match;

  // Top words land by index as the FSM sees them, the digest when the hash finishes
  always_ff @(posedge clk_i) begin
    if (exp_valid_i) begin
      exp_q[exp_idx_i] <= exp_word_i;
    end
    if (hash_done_i) begin
      digest_q <= hash_digest_i;
    end
  end

  assign hash_word  = digest_q[idx_q*rom_check_pkg::WordW +: rom_check_pkg::WordW];
  assign word_match = (hash_word == exp_q[idx_q]);

  // One word per cycle, good is only updated once the final word is in
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q  <= 1'b0;
      idx_q   <= '0;
      match_q <= 1'b0;
      done_q  <= 1'b0;
      good_q  <= 1'b0;
    end else begin
      done_q <= 1'b0;
      if (start_i) begin
        busy_q  <= 1'b1;
        idx_q   <= '0;
        match_q <= 1'b1;
      end else if (busy_q) begin
        match_q <= match_q & word_match;
        idx_q   <= idx_q + rom_check_pkg::top_idx_t'(1);
        if (idx_q == rom_check_pkg::LastTopIdx) begin
          busy_q <= 1'b0;
          done_q <= 1'b1;
          good_q <= match_q & word_match;
        end
      end
    end
  end

  assign done_o = done_q;
  assign good_o = good_q;

endmodule

// ==== src/rom_hash_engine.sv ====
// Two-lane mixing hash over the streamed non-top ROM words
// Ready/valid word input with a rest cycle after each word, done strobe at the end

`timescale 1ns/1ns

module rom_hash_engine (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  rom_check_pkg::rom_word_t  word_i,
  input  logic                      word_valid_i,
  input  logic                      word_last_i,
  output logic                      word_ready_o,
  output logic                      done_o,
  output rom_check_pkg::digest_t    digest_o
);

  // Lane 0 rotates and XORs, lane 1 sums
  rom_check_pkg::rom_word_t     lane0_q, lane1_q;
  logic                         rest_q;
  logic                         sealed_q;
  rom_check_ctrl_pkg::hash_cnt_t delay_q;
  logic                         accept;

  // No more words are taken once the last one is in
  assign word_ready_o = ~rest_q & ~sealed_q;
  assign accept       = word_valid_i & word_ready_o;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      lane0_q <= '0;
      lane1_q <= '0;
    end else if (accept) begin
      lane0_q <= {lane0_q[rom_check_pkg::WordW-2:0], lane0_q[rom_check_pkg::WordW-1]} ^ word_i;
      lane1_q <= lane1_q + word_i;
    end
  end

  // The cycle after each word is the mixing cycle, so ready drops for it
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rest_q   <= 1'b0;
      sealed_q <= 1'b0;
      delay_q  <= '0;
    end else begin
      rest_q <= accept;
      if (accept && word_last_i) begin
        sealed_q <= 1'b1;
        delay_q  <= rom_check_ctrl_pkg::hash_cnt_t'(rom_check_ctrl_pkg::HashDoneDelay);
      end else if (delay_q != '0) begin
        delay_q <= delay_q - rom_check_ctrl_pkg::hash_cnt_t'(1);
      end
    end
  end

  // Done fires in the final cycle of the countdown, with the lanes already settled
  assign done_o   = (delay_q == rom_check_ctrl_pkg::hash_cnt_t'(1));
  assign digest_o = {lane1_q, lane0_q};

endmodule

// ==== src/rom_addr_counter.sv ====
// ROM address generator for the integrity checker
// Issues one read per cycle and tracks which word sits on the ROM data bus

`timescale 1ns/1ns

module rom_addr_counter (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      data_rdy_i,
  output rom_check_pkg::rom_addr_t  read_addr_o,
  output logic                      read_req_o,
  output rom_check_pkg::rom_addr_t  data_addr_o,
  output logic                      last_nontop_o,
  output logic                      done_o
);

  // Address of the word on the data bus, and whether a read for it went out
  rom_check_pkg::rom_addr_t addr_q, addr_d;
  logic                     vld_q;
  logic                     done_q;
  logic                     consume;
  logic                     at_last;

  // The word on the bus is used up when the consumer says so
  assign consume = vld_q & data_rdy_i & ~done_q;
  assign at_last = (addr_q == rom_check_pkg::LastAddr);

  always_comb begin
    addr_d = addr_q;
    if (consume && !at_last) begin
      addr_d = addr_q + rom_check_pkg::rom_addr_t'(1);
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      addr_q <= '0;
      vld_q  <= 1'b0;
      done_q <= 1'b0;
    end else begin
      addr_q <= addr_d;
      vld_q  <= vld_q | read_req_o;
      // Once the top word is consumed the counter freezes for good
      if (consume && at_last) begin
        done_q <= 1'b1;
      end
    end
  end

  // While stalled the same address is read again, so its data stays on the bus
  assign read_addr_o   = addr_d;
  assign read_req_o    = ~done_q & ~(consume & at_last);
  assign data_addr_o   = addr_q;
  assign last_nontop_o = (addr_q == rom_check_pkg::LastNonTopAddr);
  assign done_o        = done_q;

endmodule

// ==== src/rom_check_ctrl_pkg.sv ====
// Sequencing FSM states and hash completion timing

package rom_check_ctrl_pkg;

  // Linear state order with one race branch between ROM reads and the hash
  //   ReadingLow   streaming the non-top words into the hash engine
  //   ReadingHigh  capturing the top words and waiting for both sides
  //   RomAhead     every word read, hash still busy
  //   HashAhead    hash finished, top words still being read
  //   Checking     digests compared word by word
  //   Done         terminal, the bus owns the ROM
  //   Invalid      terminal, reached only on a consistency failure
  typedef enum logic [2:0] {
    ReadingLow,
    ReadingHigh,
    RomAhead,
    HashAhead,
    Checking,
    Done,
    Invalid
  } fsm_state_e;

  // Cycles from the last accepted word to the hash done strobe
  localparam int unsigned HashDoneDelay = 2;
  localparam int unsigned HashDelayW    = $clog2(HashDoneDelay + 1);

  typedef logic [HashDelayW-1:0] hash_cnt_t;

endpackage

// ==== src/rom_check_pkg.sv ====
// ROM geometry for the boot-time integrity checker
// Word, address, digest index and whole-digest types, plus the fixed addresses they imply

package rom_check_pkg;

  // Size of the ROM and of the expected digest held in its top words
  localparam int unsigned RomDepth = 8;
  localparam int unsigned TopCount = 2;
  localparam int unsigned TopStart = RomDepth - TopCount;

  localparam int unsigned WordW   = 32;
  localparam int unsigned AddrW   = $clog2(RomDepth);
  localparam int unsigned TopIdxW = $clog2(TopCount);

  typedef logic [AddrW-1:0]   rom_addr_t;
  typedef logic [WordW-1:0]   rom_word_t;
  typedef logic [TopIdxW-1:0] top_idx_t;

  // Digest word 0 sits in the low bits
  typedef logic [TopCount*WordW-1:0] digest_t;

  // Fixed addresses that the counter and the FSM compare against
  localparam rom_addr_t LastAddr       = rom_addr_t'(RomDepth - 1);
  localparam rom_addr_t TopStartAddr   = rom_addr_t'(TopStart);
  localparam rom_addr_t LastNonTopAddr = rom_addr_t'(TopStart - 1);

  // Index of the final digest word, where the comparison ends
  localparam top_idx_t LastTopIdx = top_idx_t'(TopCount - 1);

endpackage
